// ==== common/bpm_defines.svh ====
`ifndef BPM_DEFINES_SVH
`define BPM_DEFINES_SVH

////////////////////
// sample and power widths
////////////////////
`define BPM_ADC_WIDTH    16 // signed adc sample
`define BPM_POWER_WIDTH  32 // power and gain words

// squared sample scaled down before it is summed
`define BPM_POWER_SHIFT  8

// gains are Q16.16
`define BPM_GAIN_FRAC    16

////////////////////
// event record
////////////////////
`define BPM_PACKET_PID   32'h4142504D // "ABPM"
`define BPM_PACKET_WORDS 8

// slow fifo toward the host
`define BPM_SFIFO_DEPTH  32 // words, power of two
`define BPM_SFIFO_WIDTH  32

`endif

// ==== common/bpm_pkg.sv ====
`include "bpm_defines.svh"

package bpm_pkg;

	// one signed adc sample
	typedef logic signed [`BPM_ADC_WIDTH-1:0] sample_t;

	// all four channels of one sample, a sits in the low bits
	typedef struct packed {
		sample_t d;
		sample_t c;
		sample_t b;
		sample_t a;
	} quad_sample_t;

	// fields taken from the 16-bit control word
	typedef struct packed {
		logic gain_bypass; // control bit 8
		logic run;         // control bit 0
	} ctrl_t;

	// per-channel result of one event
	typedef struct packed {
		logic [`BPM_POWER_WIDTH-1:0] power;
		sample_t                     max;
		logic                        overflow; // full-scale code seen
	} chan_result_t;

	typedef struct packed {
		logic [`BPM_POWER_WIDTH-1:0] d;
		logic [`BPM_POWER_WIDTH-1:0] c;
		logic [`BPM_POWER_WIDTH-1:0] b;
		logic [`BPM_POWER_WIDTH-1:0] a;
	} quad_power_t;

	// Q16.16 gain per channel
	typedef struct packed {
		logic [`BPM_POWER_WIDTH-1:0] d;
		logic [`BPM_POWER_WIDTH-1:0] c;
		logic [`BPM_POWER_WIDTH-1:0] b;
		logic [`BPM_POWER_WIDTH-1:0] a;
	} quad_gain_t;

	// status word, msb first
	typedef struct packed {
		logic       ovf_a;
		logic       ovf_b;
		logic       ovf_c;
		logic       ovf_d;
		logic [8:0] reserved; // always zero
		logic       drop_seen; // sticky, a record was lost
		logic       fifo_half;
		logic       run;
	} status_t;

endpackage

// ==== source/ctrl_decode.sv ====
`timescale 1ns/1ps

module ctrl_decode import bpm_pkg::*; (
	input  logic         clk,
	input  logic         RST_EVENT_NO,
	input  logic [15:0]  control_word,
	input  quad_sample_t data_in,
	input  logic         sample_valid, // level
	input  logic         event_end,    // one-cycle, last sample of event
	output ctrl_t        ctrl,
	output quad_sample_t samples,
	output logic         valid,
	output logic         evt_end
);

	ctrl_t ctrl_d; // decoded, not yet registered

	////////////////////
	// control word fields
	////////////////////
	assign ctrl_d.run         = control_word[0];
	assign ctrl_d.gain_bypass = control_word[8];
	// remaining bits belong to functions not in this chain

	////////////////////
	// strobes, gated by run
	////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			ctrl    <= '0;
			valid   <= 1'b0;
			evt_end <= 1'b0;
		end else begin
			ctrl    <= ctrl_d;
			valid   <= sample_valid & ctrl_d.run; // nothing counted while stopped
			evt_end <= event_end & ctrl_d.run;
		end
	end

	// sample data follows the strobes by the same one cycle
	always_ff @(posedge clk) begin
		samples <= data_in;
	end

endmodule

// ==== power/channel_power.sv ====
`timescale 1ns/1ps
`include "bpm_defines.svh"

module channel_power import bpm_pkg::*; (
	input  logic         clk,
	input  logic         RST_EVENT_NO,
	input  sample_t      sample,
	input  logic         valid,
	input  logic         evt_end, // last sample of event, may be valid itself
	output chan_result_t result,
	output logic         rdy      // one cycle after evt_end
);

	// full-scale codes
	localparam sample_t MAX_CODE = {1'b0, {(`BPM_ADC_WIDTH-1){1'b1}}};
	localparam sample_t MIN_CODE = {1'b1, {(`BPM_ADC_WIDTH-1){1'b0}}};

	logic signed [2*`BPM_ADC_WIDTH-1:0] sq;       // always >= 0
	logic [`BPM_POWER_WIDTH-1:0]        sq_shift;
	logic [`BPM_POWER_WIDTH:0]          sum;      // extra bit catches the carry
	logic [`BPM_POWER_WIDTH-1:0]        acc, acc_next;
	sample_t                            max_q, max_next;
	logic                               ovf_q, ovf_next;

	////////////////////
	// next values incl. current sample
	////////////////////
	assign sq       = sample * sample;
	assign sq_shift = $unsigned(sq) >> `BPM_POWER_SHIFT;
	assign sum      = {1'b0, acc} + {1'b0, sq_shift};

	assign acc_next = !valid ? acc :
		sum[`BPM_POWER_WIDTH] ? '1 : sum[`BPM_POWER_WIDTH-1:0]; // clamp at all ones

	assign max_next = (valid && (sample > max_q)) ? sample : max_q; // signed compare
	assign ovf_next = ovf_q | (valid && ((sample == MAX_CODE) || (sample == MIN_CODE)));

	// accumulators, restart right after evt_end
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			acc   <= '0;
			max_q <= MIN_CODE;
			ovf_q <= 1'b0;
			rdy   <= 1'b0;
		end else begin
			rdy <= evt_end;
			if (evt_end) begin
				acc   <= '0;
				max_q <= MIN_CODE; // empty event reports most negative code
				ovf_q <= 1'b0;
			end else begin
				acc   <= acc_next;
				max_q <= max_next;
				ovf_q <= ovf_next;
			end
		end
	end

	// result held until the next event ends
	always_ff @(posedge clk) begin
		if (evt_end) begin
			result.power    <= acc_next;
			result.max      <= max_next;
			result.overflow <= ovf_next;
		end
	end

endmodule

// ==== power/gain_adjust.sv ====
`timescale 1ns/1ps
`include "bpm_defines.svh"

module gain_adjust import bpm_pkg::*; (
	input  logic        clk,
	input  logic        RST_EVENT_NO,
	input  quad_power_t power_in,
	input  quad_gain_t  gains,   // Q16.16 per channel
	input  logic        bypass,
	input  logic        in_rdy,
	output quad_power_t power_out,
	output logic        adj_rdy  // one cycle after in_rdy
);

	////////////////////
	// power * gain, Q16.16
	////////////////////
	function automatic logic [`BPM_POWER_WIDTH-1:0] scale_power(
		input logic [`BPM_POWER_WIDTH-1:0] p,
		input logic [`BPM_POWER_WIDTH-1:0] g,
		input logic                        byp
	);
		logic [2*`BPM_POWER_WIDTH-1:0] prod;
		logic [2*`BPM_POWER_WIDTH-1:0] shifted;
		begin
			prod    = p * g;                  // full 64-bit product
			shifted = prod >> `BPM_GAIN_FRAC; // drop fraction bits
			if (byp)
				return p;                     // raw power straight through
			else if (|shifted[2*`BPM_POWER_WIDTH-1:`BPM_POWER_WIDTH])
				return '1;                    // saturate
			else
				return shifted[`BPM_POWER_WIDTH-1:0];
		end
	endfunction

	// ready strobe
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO)
			adj_rdy <= 1'b0;
		else
			adj_rdy <= in_rdy;
	end

	// adjusted powers, captured with the strobe
	always_ff @(posedge clk) begin
		if (in_rdy) begin
			power_out.a <= scale_power(power_in.a, gains.a, bypass);
			power_out.b <= scale_power(power_in.b, gains.b, bypass);
			power_out.c <= scale_power(power_in.c, gains.c, bypass);
			power_out.d <= scale_power(power_in.d, gains.d, bypass);
		end
	end

endmodule

// ==== packet/slow_fifo.sv ====
`timescale 1ns/1ps
`include "bpm_defines.svh"

module slow_fifo (
	input  logic                              clk,
	input  logic                              RST_EVENT_NO,
	input  logic                              wr_en,
	input  logic [`BPM_SFIFO_WIDTH-1:0]       wr_data,
	input  logic                              rd_en,   // pop strobe
	output logic [`BPM_SFIFO_WIDTH-1:0]       rd_data, // head word, fall-through
	output logic [$clog2(`BPM_SFIFO_DEPTH):0] count
);

	localparam int AW = $clog2(`BPM_SFIFO_DEPTH);
	localparam logic [AW:0] FULL = `BPM_SFIFO_DEPTH;

	logic [`BPM_SFIFO_WIDTH-1:0] mem [`BPM_SFIFO_DEPTH];
	logic [AW-1:0]               wr_ptr, rd_ptr; // wrap by overflow, depth is 2^n
	logic                        do_wr, do_rd;

	assign do_wr = wr_en && (count != FULL); // write to full is lost
	assign do_rd = rd_en && (count != '0);   // read of empty ignored

	// head word straight from storage
	assign rd_data = mem[rd_ptr];

	////////////////////
	// pointers and count
	////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

endmodule

// ==== packet/packet_packer.sv ====
`timescale 1ns/1ps
`include "bpm_defines.svh"

module packet_packer import bpm_pkg::*; (
	input  logic                              clk,
	input  logic                              RST_EVENT_NO,
	input  logic                              adj_rdy,
	input  quad_power_t                       power,
	input  quad_sample_t                      results_max,
	input  logic [3:0]                        overflow,   // {a, b, c, d}
	input  logic                              run,
	input  logic [$clog2(`BPM_SFIFO_DEPTH):0] fifo_count,
	output logic                              wr_en,
	output logic [`BPM_SFIFO_WIDTH-1:0]       wr_data,
	output status_t                           status
);

	localparam int CW = $clog2(`BPM_SFIFO_DEPTH) + 1; // fifo count width
	localparam logic [CW:0] ROOM_MAX = `BPM_SFIFO_DEPTH - `BPM_PACKET_WORDS;

	logic [15:0]                     evt_cnt;   // wraps, lower half of word 2
	logic                            drop_seen;
	logic [3:0]                      ovf_q;     // latest event, written or not
	logic                            busy;
	logic [$clog2(`BPM_PACKET_WORDS)-1:0] word_cnt;
	logic [CW:0]                     fill;      // count incl. write in flight
	logic                            fifo_half;
	logic                            accept;
	quad_power_t                     pwr_q;     // snapshot at adj_rdy
	quad_sample_t                    max_q;

	assign fill      = {1'b0, fifo_count} + {{CW{1'b0}}, wr_en};
	assign fifo_half = fifo_count >= (`BPM_SFIFO_DEPTH / 2);
	assign accept    = adj_rdy && !busy && (fill <= ROOM_MAX);

	assign status = '{ovf_a: ovf_q[3], ovf_b: ovf_q[2], ovf_c: ovf_q[1], ovf_d: ovf_q[0],
		reserved: '0, drop_seen: drop_seen, fifo_half: fifo_half, run: run};

	////////////////////
	// counter, drop flag, word sequencer
	////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			evt_cnt   <= '0;
			drop_seen <= 1'b0;
			ovf_q     <= '0;
			busy      <= 1'b0;
			word_cnt  <= '0;
			wr_en     <= 1'b0;
		end else begin
			if (adj_rdy) begin
				evt_cnt <= evt_cnt + 16'd1; // dropped events count too
				ovf_q   <= overflow;
				if (!accept)
					drop_seen <= 1'b1;      // sticky until reset
			end
			if (accept) begin
				busy     <= 1'b1;
				wr_en    <= 1'b1;           // pid goes out now
				word_cnt <= 1;
			end else if (busy) begin
				wr_en    <= 1'b1;
				word_cnt <= word_cnt + 1'b1;
				if (word_cnt == `BPM_PACKET_WORDS - 1)
					busy <= 1'b0;           // last word, next adj_rdy can start
			end else begin
				wr_en <= 1'b0;
			end
		end
	end

	// record payload
	always_ff @(posedge clk) begin
		if (accept) begin
			pwr_q   <= power;
			max_q   <= results_max;
			wr_data <= `BPM_PACKET_PID;
		end else if (busy) begin
			case (word_cnt)
				1:       wr_data <= {status, evt_cnt}; // count already includes this event
				2:       wr_data <= pwr_q.a;
				3:       wr_data <= pwr_q.b;
				4:       wr_data <= pwr_q.c;
				5:       wr_data <= pwr_q.d;
				6:       wr_data <= {max_q.a, max_q.b};
				7:       wr_data <= {max_q.c, max_q.d};
				default: wr_data <= `BPM_PACKET_PID;
			endcase
		end
	end

endmodule

// ==== source/bpm_sigproc_top.sv ====
`timescale 1ns/1ps
`include "bpm_defines.svh"

module bpm_sigproc_top import bpm_pkg::*; (
	input  logic                              clk,
	input  logic                              RST_EVENT_NO,
	input  logic [15:0]                       control_word,
	input  quad_sample_t                      data_in,
	input  logic                              sample_valid,
	input  logic                              event_end,
	input  quad_gain_t                        gains,
	input  logic                              fifo_rd,
	output logic [`BPM_SFIFO_WIDTH-1:0]       fifo_dout,
	output logic [$clog2(`BPM_SFIFO_DEPTH):0] fifo_count,
	output status_t                           status
);

	ctrl_t                       ctrl;
	quad_sample_t                samples;
	logic                        valid, evt_end;
	chan_result_t                res_a, res_b, res_c, res_d;
	logic                        pwr_rdy;  // channel a only, all share strobes
	quad_power_t                 raw_power, adj_power;
	logic                        adj_rdy;
	quad_sample_t                max_all;
	logic [3:0]                  ovf_all;
	logic                        wr_en;
	logic [`BPM_SFIFO_WIDTH-1:0] wr_data;

	////////////////////
	// decode
	////////////////////
	ctrl_decode u_decode (.clk, .RST_EVENT_NO, .control_word, .data_in, .sample_valid,
		.event_end, .ctrl, .samples, .valid, .evt_end);

	////////////////////
	// execute
	////////////////////
	channel_power u_pwr_a (.clk, .RST_EVENT_NO, .sample(samples.a), .valid, .evt_end,
		.result(res_a), .rdy(pwr_rdy));
	channel_power u_pwr_b (.clk, .RST_EVENT_NO, .sample(samples.b), .valid, .evt_end,
		.result(res_b), .rdy());
	channel_power u_pwr_c (.clk, .RST_EVENT_NO, .sample(samples.c), .valid, .evt_end,
		.result(res_c), .rdy());
	channel_power u_pwr_d (.clk, .RST_EVENT_NO, .sample(samples.d), .valid, .evt_end,
		.result(res_d), .rdy());

	assign raw_power = '{d: res_d.power, c: res_c.power, b: res_b.power, a: res_a.power};
	assign max_all   = '{d: res_d.max, c: res_c.max, b: res_b.max, a: res_a.max};
	assign ovf_all   = {res_a.overflow, res_b.overflow, res_c.overflow, res_d.overflow};

	gain_adjust u_gain (.clk, .RST_EVENT_NO, .power_in(raw_power), .gains,
		.bypass(ctrl.gain_bypass), .in_rdy(pwr_rdy), .power_out(adj_power), .adj_rdy);

	////////////////////
	// result
	////////////////////
	packet_packer u_packer (.clk, .RST_EVENT_NO, .adj_rdy, .power(adj_power),
		.results_max(max_all), .overflow(ovf_all), .run(ctrl.run), .fifo_count,
		.wr_en, .wr_data, .status);

	slow_fifo u_sfifo (.clk, .RST_EVENT_NO, .wr_en, .wr_data, .rd_en(fifo_rd),
		.rd_data(fifo_dout), .count(fifo_count));

endmodule

// ==== testbench/bpm_model.svh ====
`ifndef BPM_MODEL_SVH
`define BPM_MODEL_SVH

////////////////////
// reference arithmetic for one event record
////////////////////

// power after one more sample, clamped at all ones
function automatic logic [31:0] add_square(input logic [31:0] acc, input sample_t s);
	longint sq;
	longint total;
	sq    = longint'(s) * longint'(s);               // never negative
	total = longint'(acc) + (sq >>> `BPM_POWER_SHIFT);
	if (total > 64'h0000_0000_FFFF_FFFF)
		return 32'hFFFF_FFFF;
	return total[31:0];
endfunction

// Q16.16 gain, or raw power when bypassed
function automatic logic [31:0] apply_gain(input logic [31:0] p, input logic [31:0] g,
	input logic byp);
	logic [63:0] prod;
	prod = {32'd0, p} * {32'd0, g};
	prod = prod >> `BPM_GAIN_FRAC;
	if (byp)
		return p;
	if (prod[63:32] != 32'd0)
		return 32'hFFFF_FFFF; // too big for one word
	return prod[31:0];
endfunction

// most positive or most negative code
function automatic bit is_full_scale(input sample_t s);
	return (s == sample_t'(16'h7FFF)) || (s == sample_t'(16'h8000));
endfunction

// ovf is {a, b, c, d}
function automatic status_t pack_status(input logic [3:0] ovf, input logic drop,
	input logic half, input logic run);
	status_t st;
	st           = '0;
	st.ovf_a     = ovf[3];
	st.ovf_b     = ovf[2];
	st.ovf_c     = ovf[1];
	st.ovf_d     = ovf[0];
	st.drop_seen = drop;
	st.fifo_half = half;
	st.run       = run;
	return st;
endfunction

`endif

// ==== testbench/tb_bpm_sigproc.sv ====
`timescale 1ns/1ps
`include "bpm_defines.svh"

module tb_bpm_sigproc import bpm_pkg::*; ();

	// 30 gain, 10 bypass, 3 stopped, 6 drop, 1 after the drops, 1 after reset
	localparam int N_EVENTS       = 51;
	localparam int TIMEOUT_CYCLES = N_EVENTS * 80 + 500;

	logic                              clk;
	logic                              RST_EVENT_NO;
	logic [15:0]                       control_word;
	quad_sample_t                      data_in;
	logic                              sample_valid;
	logic                              event_end;
	quad_gain_t                        gains;
	logic                              fifo_rd;
	logic [`BPM_SFIFO_WIDTH-1:0]       fifo_dout;
	logic [$clog2(`BPM_SFIFO_DEPTH):0] fifo_count;
	status_t                           status;

	logic [31:0] exp_q [$]; // expected record words, oldest first
	logic [31:0] got [8];   // record just read
	logic [15:0] exp_cnt;
	logic        exp_drop;
	logic [3:0]  exp_ovf;   // {a, b, c, d}
	int          exp_fill;  // words the fifo should hold
	int          errors;
	int          checks;
	int          cycles;

	`include "bpm_model.svh"

	bpm_sigproc_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("errors: %0d, checks: %0d", errors + 1, checks);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////
	// compare tasks
	////////////////////
	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_power(input string name, input logic [`BPM_POWER_WIDTH-1:0] exp,
		input logic [`BPM_POWER_WIDTH-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input status_t exp, input status_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	////////////////////
	// stimulus helpers
	////////////////////
	task automatic step();
		@(posedge clk);
		#5; // inputs move just after the edge
	endtask

	function automatic sample_t rand_sample(input bit full_scale);
		int pick;
		pick = $urandom_range(15);
		if (full_scale && pick == 0)
			return sample_t'(16'h7FFF);
		if (full_scale && pick == 1)
			return sample_t'(16'h8000);
		return sample_t'($urandom);
	endfunction

	function automatic logic [31:0] rand_gain();
		int pick;
		pick = $urandom_range(7);
		if (pick == 0)
			return $urandom;           // mostly saturates
		if (pick == 1)
			return 32'h0001_0000;      // unity
		return $urandom & 32'h0003_FFFF; // below 4.0
	endfunction

	task automatic apply_reset();
		RST_EVENT_NO = 1'b1;
		repeat (3) step();
		RST_EVENT_NO = 1'b0;
		exp_cnt  = '0;
		exp_drop = 1'b0;
		exp_ovf  = '0;
		exp_fill = 0;
		exp_q.delete();
	endtask

	// n valid samples, last one carries event_end
	task automatic run_event(input int n, input bit full_scale);
		logic [31:0]  acc [4];
		sample_t      mx [4];
		logic [3:0]   ovf;  // index is channel, a = 0
		quad_sample_t q;
		status_t      st;
		for (int i = 0; i < 4; i++) begin
			acc[i] = '0;
			mx[i]  = sample_t'(16'h8000);
		end
		ovf = '0;
		for (int k = 0; k < n; k++) begin
			if ($urandom_range(3) == 0) begin // idle gap
				sample_valid = 1'b0;
				data_in      = quad_sample_t'({$urandom, $urandom});
				step();
			end
			q            = {rand_sample(full_scale), rand_sample(full_scale),
				rand_sample(full_scale), rand_sample(full_scale)};
			data_in      = q;
			sample_valid = 1'b1;
			event_end    = (k == n - 1);
			for (int i = 0; i < 4; i++) begin
				acc[i] = add_square(acc[i], sample_t'(q[16*i +: 16]));
				if (sample_t'(q[16*i +: 16]) > mx[i])
					mx[i] = sample_t'(q[16*i +: 16]);
				ovf[i] = ovf[i] | is_full_scale(sample_t'(q[16*i +: 16]));
			end
			step();
		end
		sample_valid = 1'b0;
		event_end    = 1'b0;
		repeat (20) step(); // well past the 5 cycle chain
		if (control_word[0]) begin
			exp_cnt = exp_cnt + 16'd1; // dropped ones count too
			exp_ovf = {ovf[0], ovf[1], ovf[2], ovf[3]};
			if (exp_fill <= `BPM_SFIFO_DEPTH - `BPM_PACKET_WORDS) begin
				st = pack_status(exp_ovf, exp_drop, exp_fill >= `BPM_SFIFO_DEPTH / 2, 1'b1);
				exp_q.push_back(`BPM_PACKET_PID);
				exp_q.push_back({st, exp_cnt});
				for (int i = 0; i < 4; i++)
					exp_q.push_back(apply_gain(acc[i], gains[32*i +: 32], control_word[8]));
				exp_q.push_back({mx[0], mx[1]});
				exp_q.push_back({mx[2], mx[3]});
				exp_fill = exp_fill + `BPM_PACKET_WORDS;
			end else begin
				exp_drop = 1'b1;
			end
		end
	endtask

	task automatic check_idle_status(input string name);
		check_status({name, " status"}, pack_status(exp_ovf, exp_drop,
			exp_fill >= `BPM_SFIFO_DEPTH / 2, control_word[0]), status);
	endtask

	////////////////////
	// fifo readout
	////////////////////
	task automatic drain_fifo(input string name);
		logic [31:0] want [8];
		check_word({name, " fifo count"}, exp_fill, {26'd0, fifo_count});
		while (exp_q.size() >= `BPM_PACKET_WORDS) begin
			for (int w = 0; w < 8; w++) begin
				if (fifo_count == 0) begin
					errors++;
					$display("%s: FIFO ran empty in the middle of a record", name);
				end
				got[w]  = fifo_dout; // head word, stable since the edge
				fifo_rd = 1'b1;
				step();
				fifo_rd = 1'b0;
			end
			for (int w = 0; w < 8; w++)
				want[w] = exp_q.pop_front();
			check_word({name, " pid"}, want[0], got[0]);
			check_status({name, " record status"}, status_t'(want[1][31:16]),
				status_t'(got[1][31:16]));
			check_word({name, " event count"}, {16'd0, want[1][15:0]}, {16'd0, got[1][15:0]});
			check_power({name, " power a"}, want[2], got[2]);
			check_power({name, " power b"}, want[3], got[3]);
			check_power({name, " power c"}, want[4], got[4]);
			check_power({name, " power d"}, want[5], got[5]);
			check_sample({name, " max a"}, sample_t'(want[6][31:16]), sample_t'(got[6][31:16]));
			check_sample({name, " max b"}, sample_t'(want[6][15:0]), sample_t'(got[6][15:0]));
			check_sample({name, " max c"}, sample_t'(want[7][31:16]), sample_t'(got[7][31:16]));
			check_sample({name, " max d"}, sample_t'(want[7][15:0]), sample_t'(got[7][15:0]));
		end
		exp_fill = 0;
		check_word({name, " empty count"}, 32'd0, {26'd0, fifo_count});
		check_idle_status(name);
	endtask

	////////////////////
	// test sequence
	////////////////////
	initial begin
		void'($urandom(32'h52246686));
		RST_EVENT_NO = 1'b1;
		control_word = 16'h0001; // run, gain applied
		data_in      = '0;
		sample_valid = 1'b0;
		event_end    = 1'b0;
		gains        = '0;
		fifo_rd      = 1'b0;
		apply_reset();

		// gain applied, full-scale codes on every other event
		for (int e = 0; e < 30; e++) begin
			gains = {rand_gain(), rand_gain(), rand_gain(), rand_gain()};
			step();
			run_event($urandom_range(40, 1), e[0]);
			drain_fifo($sformatf("power ev%0d", e));
		end

		// bypass, powers are raw sums
		control_word = 16'h0101;
		for (int e = 0; e < 10; e++) begin
			gains = {rand_gain(), rand_gain(), rand_gain(), rand_gain()};
			step();
			run_event($urandom_range(40, 1), e[0]);
			drain_fifo($sformatf("bypass ev%0d", e));
		end

		// stopped, nothing recorded
		control_word = 16'h0000;
		for (int e = 0; e < 3; e++) begin
			step();
			run_event($urandom_range(40, 1), 1'b1);
			drain_fifo($sformatf("stopped ev%0d", e));
		end

		// no reads, fifo fills after 4 records
		control_word = 16'h0001;
		step();
		for (int e = 0; e < 6; e++)
			run_event($urandom_range(40, 1), 1'b1);
		check_idle_status("drop full");
		drain_fifo("drop");

		// count went on through the two lost records
		run_event($urandom_range(40, 1), 1'b1);
		drain_fifo("after drop");

		// counter restarts
		apply_reset();
		run_event($urandom_range(40, 1), 1'b1);
		drain_fifo("after reset");

		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+common
+incdir+testbench
common/bpm_pkg.sv
source/ctrl_decode.sv
power/channel_power.sv
power/gain_adjust.sv
packet/slow_fifo.sv
packet/packet_packer.sv
source/bpm_sigproc_top.sv
testbench/tb_bpm_sigproc.sv

// ==== Makefile ====
# Verilator build and run of the BPM signal chain testbench

SIM  := obj_dir/Vtb_bpm_sigproc
SRCS := $(filter-out +%,$(shell cat sources.f)) common/bpm_defines.svh testbench/bpm_model.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): sources.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_bpm_sigproc -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -qx 'PASS: all tests' sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
